/* build.f */
+incdir+src
+incdir+tb
src/ntt_ctrl_pkg.sv
src/ntt_wen_delay.sv
src/ntt_index_gen.sv
src/ntt_phase_fsm.sv
src/ntt_ctrl_top.sv
tb/ntt_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it into a log and look for the pass line

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f build.f --top-module ntt_ctrl_tb -Mdir "$build_dir" -o ntt_ctrl_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/ntt_ctrl_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$log_file"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1

/* src/ntt_ctrl_pkg.sv */
`include "ntt_ctrl_settings.svh"

package ntt_ctrl_pkg;

  //////////////////////////////
  // Schedule phases
  //////////////////////////////

  typedef enum logic [2:0] {
    idle,
    fwd_sweep,
    product_sweep,
    fwd_drain,
    inv_sweep,
    inv_drain,
    done
  } phase_t;

  //////////////////////////////
  // Index and span vectors
  //////////////////////////////

  // Stage number counts 0 up to NTT_LOG_N
  typedef logic [$clog2(`NTT_LOG_N + 1)-1:0] stage_t;

  // Butterfly span is a power of two up to NTT_N
  typedef logic [`NTT_LOG_N:0] span_t;

  // Shared by the row, group and single-step indices
  typedef logic [$clog2(`NTT_ROWS)-1:0] row_t;

endpackage

/* src/ntt_ctrl_settings.svh */
`ifndef NTT_CTRL_SETTINGS_SVH
`define NTT_CTRL_SETTINGS_SVH

//////////////////////////////
// Transform geometry
//////////////////////////////

// Base-2 log of the transform length and the top stage number
`define NTT_LOG_N 9

`define NTT_N 512

// Issue cycles in one stage and in the product sweep
`define NTT_ROWS 128

// Butterfly pipeline latency from read issue to bank write
`define NTT_PIPE_DEPTH 13

`endif

/* src/ntt_ctrl_top.sv */
`timescale 1ns/10ps
`include "ntt_ctrl_settings.svh"

module ntt_ctrl_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  output ntt_ctrl_pkg::span_t  span,
  output ntt_ctrl_pkg::stage_t stage,
  output ntt_ctrl_pkg::row_t   s,
  output ntt_ctrl_pkg::row_t   k,
  output ntt_ctrl_pkg::row_t   i,
  output logic                 fwd,
  output logic                 xform,
  output logic                 ren,
  output logic                 en,
  output logic                 wen,
  output logic                 wen_b,
  output logic                 done
);

  ntt_ctrl_pkg::phase_t phase;
  logic                 sweep_last;
  logic                 wen_issue;
  logic                 wen_b_issue;

  //////////////////////////////
  // Schedule sequencing
  //////////////////////////////

  ntt_phase_fsm u_phase_fsm (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .sweep_last  (sweep_last),
    .phase       (phase),
    .fwd         (fwd),
    .xform       (xform),
    .ren         (ren),
    .en          (en),
    .done        (done),
    .wen_issue   (wen_issue),
    .wen_b_issue (wen_b_issue)
  );

  // The index walk alone decides where each sweep ends
  ntt_index_gen u_index_gen (
    .clk        (clk),
    .rst        (rst),
    .phase      (phase),
    .stage      (stage),
    .span       (span),
    .s          (s),
    .k          (k),
    .i          (i),
    .sweep_last (sweep_last)
  );

  //////////////////////////////
  // Write enable alignment
  //////////////////////////////

  ntt_wen_delay #(
    .DEPTH (`NTT_PIPE_DEPTH)
  ) u_wen_delay (
    .clk         (clk),
    .rst         (rst),
    .wen_issue   (wen_issue),
    .wen_b_issue (wen_b_issue),
    .wen         (wen),
    .wen_b       (wen_b)
  );

endmodule

/* src/ntt_index_gen.sv */
`timescale 1ns/10ps
`include "ntt_ctrl_settings.svh"

module ntt_index_gen (
  input  logic                 clk,
  input  logic                 rst,
  input  ntt_ctrl_pkg::phase_t phase,
  output ntt_ctrl_pkg::stage_t stage,
  output ntt_ctrl_pkg::span_t  span,
  output ntt_ctrl_pkg::row_t   s,
  output ntt_ctrl_pkg::row_t   k,
  output ntt_ctrl_pkg::row_t   i,
  output logic                 sweep_last
);

  localparam ntt_ctrl_pkg::stage_t STAGE_TOP = ntt_ctrl_pkg::stage_t'(`NTT_LOG_N);
  localparam ntt_ctrl_pkg::stage_t STAGE_ONE = ntt_ctrl_pkg::stage_t'(1);
  localparam ntt_ctrl_pkg::span_t  SPAN_TOP  = ntt_ctrl_pkg::span_t'(`NTT_N);
  localparam ntt_ctrl_pkg::span_t  SPAN_ONE  = ntt_ctrl_pkg::span_t'(1);
  localparam ntt_ctrl_pkg::span_t  SPAN_WIDE = ntt_ctrl_pkg::span_t'(4);
  localparam ntt_ctrl_pkg::row_t   ROW_LAST  = ntt_ctrl_pkg::row_t'(`NTT_ROWS - 1);
  localparam ntt_ctrl_pkg::row_t   ROW_ONE   = ntt_ctrl_pkg::row_t'(1);

  logic                 span_wide;
  ntt_ctrl_pkg::span_t  group_cnt;
  ntt_ctrl_pkg::row_t   i_last;
  ntt_ctrl_pkg::row_t   k_last;
  logic                 i_wrap;
  logic                 k_wrap;
  logic                 s_wrap;

  //////////////////////////////
  // Loop limits
  //////////////////////////////

  // Spans of 4 and up walk rows and groups, spans 1 and 2 use the step index
  assign span_wide = (span >= SPAN_WIDE);

  // Only meaningful while span_wide holds, where both limits fit a row index
  assign group_cnt = SPAN_TOP >> stage;
  assign k_last    = ntt_ctrl_pkg::row_t'(group_cnt - SPAN_ONE);
  assign i_last    = ntt_ctrl_pkg::row_t'((span >> 2) - SPAN_ONE);

  assign i_wrap = (i == i_last);
  assign k_wrap = (k == k_last);
  assign s_wrap = (s == ROW_LAST);

  always_comb begin
    case (phase)
      ntt_ctrl_pkg::fwd_sweep: begin
        sweep_last = (stage == '0) && (span == SPAN_ONE) && s_wrap;
      end
      ntt_ctrl_pkg::product_sweep: begin
        sweep_last = s_wrap;
      end
      ntt_ctrl_pkg::inv_sweep: begin
        sweep_last = (stage == STAGE_TOP) && (span == SPAN_TOP) && (k == '0) && i_wrap;
      end
      default: begin
        sweep_last = 1'b0;
      end
    endcase
  end

  //////////////////////////////
  // Index counters
  //////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stage <= STAGE_TOP;
      span  <= SPAN_TOP;
      s     <= '0;
      k     <= '0;
      i     <= '0;
    end else begin
      case (phase)
        ntt_ctrl_pkg::fwd_sweep: begin
          if (span_wide) begin
            if (i_wrap) begin
              i <= '0;
              if (k_wrap) begin
                k     <= '0;
                stage <= stage - STAGE_ONE;
                span  <= span >> 1;
              end else begin
                k <= k + ROW_ONE;
              end
            end else begin
              i <= i + ROW_ONE;
            end
          end else if (s_wrap) begin
            s <= '0;
            // The last stage holds at span 1 for the product sweep
            if (stage != '0) begin
              stage <= stage - STAGE_ONE;
              span  <= span >> 1;
            end
          end else begin
            s <= s + ROW_ONE;
          end
        end
        ntt_ctrl_pkg::product_sweep: begin
          stage <= '0;
          span  <= SPAN_ONE;
          if (s_wrap) begin
            s <= '0;
          end else begin
            s <= s + ROW_ONE;
          end
        end
        ntt_ctrl_pkg::inv_sweep: begin
          if (span_wide) begin
            if (i_wrap) begin
              i <= '0;
              if (k_wrap) begin
                k <= '0;
                if (stage == STAGE_TOP) begin
                  stage <= '0;
                  span  <= SPAN_ONE;
                end else begin
                  stage <= stage + STAGE_ONE;
                  span  <= span << 1;
                end
              end else begin
                k <= k + ROW_ONE;
              end
            end else begin
              i <= i + ROW_ONE;
            end
          end else if (s_wrap) begin
            s     <= '0;
            stage <= stage + STAGE_ONE;
            span  <= span << 1;
          end else begin
            s <= s + ROW_ONE;
          end
        end
        ntt_ctrl_pkg::fwd_drain, ntt_ctrl_pkg::inv_drain: begin
          // Drains park on the inverse entry point
          stage <= '0;
          span  <= SPAN_ONE;
          s     <= '0;
          k     <= '0;
          i     <= '0;
        end
        default: begin
          // Idle and done reload the forward entry point
          stage <= STAGE_TOP;
          span  <= SPAN_TOP;
          s     <= '0;
          k     <= '0;
          i     <= '0;
        end
      endcase
    end
  end

endmodule

/* src/ntt_phase_fsm.sv */
`timescale 1ns/10ps
`include "ntt_ctrl_settings.svh"

module ntt_phase_fsm (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 sweep_last,
  output ntt_ctrl_pkg::phase_t phase,
  output logic                 fwd,
  output logic                 xform,
  output logic                 ren,
  output logic                 en,
  output logic                 done,
  output logic                 wen_issue,
  output logic                 wen_b_issue
);

  localparam int DRAIN_W = $clog2(`NTT_PIPE_DEPTH + 1);
  localparam logic [DRAIN_W-1:0] DRAIN_LAST = DRAIN_W'(`NTT_PIPE_DEPTH - 1);
  localparam logic [DRAIN_W-1:0] DRAIN_ONE = DRAIN_W'(1);

  ntt_ctrl_pkg::phase_t phase_next;
  logic [DRAIN_W-1:0]   drain_cnt;
  logic                 in_drain;
  logic                 drain_end;

  //////////////////////////////
  // Phase register
  //////////////////////////////

  assign in_drain  = (phase == ntt_ctrl_pkg::fwd_drain) || (phase == ntt_ctrl_pkg::inv_drain);
  assign drain_end = in_drain && (drain_cnt == DRAIN_LAST);

  always_comb begin
    phase_next = phase;
    case (phase)
      ntt_ctrl_pkg::idle: begin
        if (start) begin
          phase_next = ntt_ctrl_pkg::fwd_sweep;
        end
      end
      ntt_ctrl_pkg::fwd_sweep: begin
        if (sweep_last) begin
          phase_next = ntt_ctrl_pkg::product_sweep;
        end
      end
      ntt_ctrl_pkg::product_sweep: begin
        if (sweep_last) begin
          phase_next = ntt_ctrl_pkg::fwd_drain;
        end
      end
      ntt_ctrl_pkg::fwd_drain: begin
        if (drain_end) begin
          phase_next = ntt_ctrl_pkg::inv_sweep;
        end
      end
      ntt_ctrl_pkg::inv_sweep: begin
        if (sweep_last) begin
          phase_next = ntt_ctrl_pkg::inv_drain;
        end
      end
      ntt_ctrl_pkg::inv_drain: begin
        if (drain_end) begin
          phase_next = ntt_ctrl_pkg::done;
        end
      end
      ntt_ctrl_pkg::done: begin
        phase_next = ntt_ctrl_pkg::idle;
      end
      default: begin
        phase_next = ntt_ctrl_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase <= ntt_ctrl_pkg::idle;
    end else begin
      phase <= phase_next;
    end
  end

  // Counts the cycles of either drain so the last write leaves the pipeline
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      drain_cnt <= '0;
    end else if (in_drain && !drain_end) begin
      drain_cnt <= drain_cnt + DRAIN_ONE;
    end else begin
      drain_cnt <= '0;
    end
  end

  //////////////////////////////
  // Output decode
  //////////////////////////////

  assign ren = (phase == ntt_ctrl_pkg::fwd_sweep) ||
               (phase == ntt_ctrl_pkg::product_sweep) ||
               (phase == ntt_ctrl_pkg::inv_sweep);

  assign en    = (phase != ntt_ctrl_pkg::idle) && (phase != ntt_ctrl_pkg::done);
  assign fwd   = (phase != ntt_ctrl_pkg::inv_sweep) && (phase != ntt_ctrl_pkg::inv_drain);
  assign xform = (phase != ntt_ctrl_pkg::product_sweep);
  assign done  = (phase == ntt_ctrl_pkg::done);

  // Bank B is only read during the inverse sweep, never written
  assign wen_issue   = ren;
  assign wen_b_issue = ren && (phase != ntt_ctrl_pkg::inv_sweep);

endmodule

/* src/ntt_wen_delay.sv */
`timescale 1ns/10ps
`include "ntt_ctrl_settings.svh"

module ntt_wen_delay #(
  parameter int DEPTH = `NTT_PIPE_DEPTH
) (
  input  logic clk,
  input  logic rst,
  input  logic wen_issue,
  input  logic wen_b_issue,
  output logic wen,
  output logic wen_b
);

  // Bit 0 carries the bank A enable, bit 1 the bank B enable
  logic [DEPTH-1:0][1:0] pipe;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pipe <= '0;
    end else begin
      pipe[0] <= {wen_b_issue, wen_issue};
      for (int n = 1; n < DEPTH; n++) begin
        pipe[n] <= pipe[n-1];
      end
    end
  end

  assign wen   = pipe[DEPTH-1][0];
  assign wen_b = pipe[DEPTH-1][1];

endmodule

/* tb/ntt_ctrl_checks.svh */
`ifndef NTT_CTRL_CHECKS_SVH
`define NTT_CTRL_CHECKS_SVH

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic check_span(string name, ntt_ctrl_pkg::span_t got, ntt_ctrl_pkg::span_t exp);
  if (got !== exp) begin
    halt_sim($sformatf("[ERROR] %s = 0x%h, expected 0x%h (cycle %0d)", name, got, exp,
                       run_cycle));
  end
endtask

task automatic check_stage(string name, ntt_ctrl_pkg::stage_t got,
                           ntt_ctrl_pkg::stage_t exp);
  if (got !== exp) begin
    halt_sim($sformatf("[ERROR] %s = 0x%h, expected 0x%h (cycle %0d)", name, got, exp,
                       run_cycle));
  end
endtask

task automatic check_row(string name, ntt_ctrl_pkg::row_t got, ntt_ctrl_pkg::row_t exp);
  if (got !== exp) begin
    halt_sim($sformatf("[ERROR] %s = 0x%h, expected 0x%h (cycle %0d)", name, got, exp,
                       run_cycle));
  end
endtask

task automatic check_bit(string name, logic got, logic exp);
  if (got !== exp) begin
    halt_sim($sformatf("[ERROR] %s = 0x%h, expected 0x%h (cycle %0d)", name, got, exp,
                       run_cycle));
  end
endtask

//////////////////////////////
// Bounded waits
//////////////////////////////

// The controller sits in idle until the first read issue shows up
task automatic wait_ren(input int limit, output int waited);
  waited = 0;
  while (!ren) begin
    if (waited >= limit) begin
      halt_sim("Timed out waiting for ren after the start pulse");
    end
    check_indices(`NTT_LOG_N, `NTT_N, 0, 0, 0);
    step_cycle(ntt_ctrl_pkg::idle);
    waited++;
  end
endtask

// Every cycle before done is expected to belong to the inverse drain
task automatic wait_done(input int limit, output int waited);
  waited = 0;
  while (!done) begin
    if (waited >= limit) begin
      halt_sim("Timed out waiting for the done pulse after the inverse sweep");
    end
    check_indices(0, 1, 0, 0, 0);
    step_cycle(ntt_ctrl_pkg::inv_drain);
    waited++;
  end
endtask

`endif

/* tb/ntt_ctrl_tb.sv */
`timescale 1ns/10ps
`include "ntt_ctrl_settings.svh"

module ntt_ctrl_tb;

  // Cycles from the first ren to done span two transforms, the product sweep and two drains
  localparam int DONE_LATENCY = 2 * (`NTT_LOG_N + 1) * `NTT_ROWS + `NTT_ROWS +
                                2 * `NTT_PIPE_DEPTH;

  logic                 clk;
  logic                 rst;
  logic                 start;
  ntt_ctrl_pkg::span_t  span;
  ntt_ctrl_pkg::stage_t stage;
  ntt_ctrl_pkg::row_t   s;
  ntt_ctrl_pkg::row_t   k;
  ntt_ctrl_pkg::row_t   i;
  logic                 fwd;
  logic                 xform;
  logic                 ren;
  logic                 en;
  logic                 wen;
  logic                 wen_b;
  logic                 done;

  logic [31:0]                lcg_state;
  logic [`NTT_PIPE_DEPTH-1:0] ren_hist;
  logic [`NTT_PIPE_DEPTH-1:0] wen_b_hist;
  int                         run_cycle;
  int                         noise_a;
  int                         noise_b;

  ntt_ctrl_top UUT (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .span  (span),
    .stage (stage),
    .s     (s),
    .k     (k),
    .i     (i),
    .fwd   (fwd),
    .xform (xform),
    .ren   (ren),
    .en    (en),
    .wen   (wen),
    .wen_b (wen_b),
    .done  (done)
  );

  task automatic halt_sim(string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at %0t", $time);
  endtask

  function automatic int lcg_pick(int range);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[30:16]) % range;
  endfunction

  `include "ntt_ctrl_checks.svh"

  //////////////////////////////
  // Reference schedule
  //////////////////////////////

  task automatic check_indices(int st, int sp, int ss, int kk, int ii);
    check_stage("stage", stage, ntt_ctrl_pkg::stage_t'(st));
    check_span("span", span, ntt_ctrl_pkg::span_t'(sp));
    check_row("s", s, ntt_ctrl_pkg::row_t'(ss));
    check_row("k", k, ntt_ctrl_pkg::row_t'(kk));
    check_row("i", i, ntt_ctrl_pkg::row_t'(ii));
  endtask

  // Checks the control outputs of one cycle, then moves to the next falling edge
  task automatic step_cycle(ntt_ctrl_pkg::phase_t ph);
    logic e_ren;
    logic e_fwd;
    e_ren = (ph == ntt_ctrl_pkg::fwd_sweep) || (ph == ntt_ctrl_pkg::product_sweep) ||
            (ph == ntt_ctrl_pkg::inv_sweep);
    e_fwd = (ph != ntt_ctrl_pkg::inv_sweep) && (ph != ntt_ctrl_pkg::inv_drain);
    check_bit("ren", ren, e_ren);
    check_bit("en", en, (ph != ntt_ctrl_pkg::idle) && (ph != ntt_ctrl_pkg::done));
    check_bit("fwd", fwd, e_fwd);
    check_bit("xform", xform, ph != ntt_ctrl_pkg::product_sweep);
    check_bit("done", done, ph == ntt_ctrl_pkg::done);
    check_bit("wen", wen, ren_hist[`NTT_PIPE_DEPTH-1]);
    check_bit("wen_b", wen_b, wen_b_hist[`NTT_PIPE_DEPTH-1]);
    ren_hist   = {ren_hist[`NTT_PIPE_DEPTH-2:0], e_ren};
    wen_b_hist = {wen_b_hist[`NTT_PIPE_DEPTH-2:0], e_ren && e_fwd};
    @(negedge clk);
    run_cycle++;
    start = (run_cycle == noise_a) || (run_cycle == noise_b);
  endtask

  task automatic sweep_stage(ntt_ctrl_pkg::phase_t ph, int st);
    int sp;
    int kk;
    int ii;
    int ss;
    sp = 1 << st;
    if (sp >= 4) begin
      for (kk = 0; kk < (`NTT_N >> st); kk++) begin
        for (ii = 0; ii < sp / 4; ii++) begin
          check_indices(st, sp, 0, kk, ii);
          step_cycle(ph);
        end
      end
    end else begin
      for (ss = 0; ss < `NTT_ROWS; ss++) begin
        check_indices(st, sp, ss, 0, 0);
        step_cycle(ph);
      end
    end
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      check_indices(`NTT_LOG_N, `NTT_N, 0, 0, 0);
      step_cycle(ntt_ctrl_pkg::idle);
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic run_schedule();
    int st;
    int waited;
    // Stray start pulses land inside the run and must change nothing
    noise_a = 1 + lcg_pick(1400);
    noise_b = 1400 + lcg_pick(1300);
    start = 1'b1;
    run_cycle = -1;
    idle_cycles(1);
    wait_ren(4, waited);
    if (waited != 0) begin
      halt_sim("ren did not rise on the cycle after the start pulse");
    end
    for (st = `NTT_LOG_N; st >= 0; st--) begin
      sweep_stage(ntt_ctrl_pkg::fwd_sweep, st);
    end
    sweep_stage(ntt_ctrl_pkg::product_sweep, 0);
    repeat (`NTT_PIPE_DEPTH) begin
      check_indices(0, 1, 0, 0, 0);
      step_cycle(ntt_ctrl_pkg::fwd_drain);
    end
    for (st = 0; st <= `NTT_LOG_N; st++) begin
      sweep_stage(ntt_ctrl_pkg::inv_sweep, st);
    end
    wait_done(2 * `NTT_PIPE_DEPTH, waited);
    if (run_cycle != DONE_LATENCY) begin
      halt_sim($sformatf("done arrived %0d cycles after the first ren instead of %0d",
                         run_cycle, DONE_LATENCY));
    end
    check_indices(0, 1, 0, 0, 0);
    step_cycle(ntt_ctrl_pkg::done);
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst        = 1'b1;
    start      = 1'b0;
    lcg_state  = 32'd81;
    ren_hist   = '0;
    wen_b_hist = '0;
    run_cycle  = 0;
    noise_a    = -1;
    noise_b    = -1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idle_cycles(6);
    repeat (3) begin
      run_schedule();
      idle_cycles(2 + lcg_pick(24));
    end
    $display("** PASS **");
    $finish;
  end

endmodule
